//--- Bender.yml
package:
  name: lpif_x16_master

sources:
  - lpif_pkg.sv
  - lpif_auto_sync.sv
  - lpif_user_pack.sv
  - lpif_lane_concat.sv
  - lpif_x16_master_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_lpif_x16_master.sv

//--- lpif_auto_sync.sv
`timescale 1ns/1ps
`default_nettype none

module lpif_auto_sync
  import lpif_pkg::*;
#(
  parameter int STROBE_PERIOD = 16
) (
  input  wire logic   clk_wr,
  input  wire logic   reset,
  input  wire logic   tx_online,
  input  wire logic   rx_online,
  input  wire delay_t delay_x_value,
  input  wire delay_t delay_y_value,
  input  wire delay_t delay_z_value,
  output logic        tx_online_delay,
  output logic        rx_online_delay,
  output logic        tx_stb_userbit,
  output logic        tx_mrk_userbit
);

  localparam int stb_cnt_width = $clog2(STROBE_PERIOD);
  localparam logic [stb_cnt_width-1:0] stb_cnt_last = stb_cnt_width'(STROBE_PERIOD - 1);

  sync_state_t                tx_state;
  delay_t                     tx_cnt;
  delay_t                     rx_cnt;
  logic [stb_cnt_width-1:0]   stb_cnt;

  //////////////////////////////////////////////////
  // Tx online sequencer
  //////////////////////////////////////////////////

  // Every edge with tx_online high uses up one unit of y, then of z
  always_ff @(posedge clk_wr) begin
    if (reset || !tx_online) begin
      tx_state <= sync_off;
      tx_cnt   <= '0;
    end else begin
      case (tx_state)
        sync_off: begin
          if (delay_y_value > 16'd1) begin
            tx_state <= sync_count_y;
            tx_cnt   <= delay_y_value - 16'd1;
          end else if (delay_y_value == 16'd1) begin
            if (delay_z_value == '0) begin
              tx_state <= sync_online;
            end else begin
              tx_state <= sync_count_z;
              tx_cnt   <= delay_z_value;
            end
          end else if (delay_z_value <= 16'd1) begin
            // Zero total delay still costs this edge
            tx_state <= sync_online;
          end else begin
            tx_state <= sync_count_z;
            tx_cnt   <= delay_z_value - 16'd1;
          end
        end
        sync_count_y: begin
          if (tx_cnt > 16'd1) begin
            tx_cnt <= tx_cnt - 16'd1;
          end else if (delay_z_value == '0) begin
            tx_state <= sync_online;
          end else begin
            tx_state <= sync_count_z;
            tx_cnt   <= delay_z_value;
          end
        end
        sync_count_z: begin
          if (tx_cnt > 16'd1) begin
            tx_cnt <= tx_cnt - 16'd1;
          end else begin
            tx_state <= sync_online;
          end
        end
        default: tx_state <= sync_online;
      endcase
    end
  end

  assign tx_online_delay = (tx_state == sync_online);

  //////////////////////////////////////////////////
  // Rx online delay
  //////////////////////////////////////////////////

  always_ff @(posedge clk_wr) begin
    if (reset || !rx_online) begin
      rx_cnt          <= '0;
      rx_online_delay <= 1'b0;
    end else if (!rx_online_delay) begin
      if (delay_x_value == '0 || rx_cnt == delay_x_value - 16'd1) begin
        rx_online_delay <= 1'b1;
      end else begin
        rx_cnt <= rx_cnt + 16'd1;
      end
    end
  end

  //////////////////////////////////////////////////
  // Userbits
  //////////////////////////////////////////////////

  // Held at zero until online, so the first online cycle strobes
  always_ff @(posedge clk_wr) begin
    if (reset || !tx_online_delay) begin
      stb_cnt <= '0;
    end else if (stb_cnt == stb_cnt_last) begin
      stb_cnt <= '0;
    end else begin
      stb_cnt <= stb_cnt + 1'b1;
    end
  end

  assign tx_stb_userbit = tx_online_delay && (stb_cnt == '0);

  // Persistent marker
  assign tx_mrk_userbit = tx_online_delay;

  // First online cycle always strobes
  a_stb_on_first_online: assert property (
    @(posedge clk_wr) disable iff (reset)
    $rose(tx_online_delay) |-> tx_stb_userbit
  );

  // A counting state always has cycles left
  a_count_not_empty: assert property (
    @(posedge clk_wr) disable iff (reset)
    (tx_state == sync_count_y || tx_state == sync_count_z) |-> (tx_cnt != '0)
  );

endmodule

`default_nettype wire

//--- lpif_lane_concat.sv
`timescale 1ns/1ps
`default_nettype none

module lpif_lane_concat
  import lpif_pkg::*;
(
  input  wire logic       clk_wr,
  input  wire logic       reset,

  // Tx side
  input  wire lpif_word_t tx_word,
  input  wire logic       tx_online_delay,
  input  wire logic       tx_stb_userbit,
  input  wire logic       tx_mrk_userbit,
  output lane_bus_t       tx_phy,

  // Rx side
  input  wire lane_bus_t  rx_phy,
  output lpif_word_t      rx_word
);

  // Payload capacity over all lanes, 608 bits
  localparam int flat_width = num_lanes * lane_payload_width;

  logic [flat_width-1:0] tx_flat;
  logic [flat_width-1:0] rx_flat;
  lane_bus_t             tx_lanes;

  //////////////////////////////////////////////////
  // Tx scatter
  //////////////////////////////////////////////////

  always_comb begin
    tx_flat                        = '0;
    tx_flat[link_word_width-1:0]   = tx_word;
    for (int k = 0; k < num_lanes; k++) begin
      tx_lanes[k] = '0;
      tx_lanes[k][lane_payload_width-1:0] =
        tx_flat[k*lane_payload_width +: lane_payload_width];
      // Strobe rides on lane 0 only
      tx_lanes[k][stb_bit] = (k == 0) ? tx_stb_userbit : 1'b0;
      tx_lanes[k][mrk_bit] = tx_mrk_userbit;
    end
  end

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      tx_phy <= '0;
    end else if (tx_online_delay) begin
      tx_phy <= tx_lanes;
    end else begin
      // Quiet lanes until the link is up
      tx_phy <= '0;
    end
  end

  //////////////////////////////////////////////////
  // Rx gather
  //////////////////////////////////////////////////

  // Userbits on bits 38 and 39 are dropped here
  always_comb begin
    for (int k = 0; k < num_lanes; k++) begin
      rx_flat[k*lane_payload_width +: lane_payload_width] =
        rx_phy[k][lane_payload_width-1:0];
    end
  end

  always_ff @(posedge clk_wr) begin
    rx_word <= rx_flat[link_word_width-1:0];
  end

  // No marker on the previous cycle means the link was down
  a_offline_lanes_quiet: assert property (
    @(posedge clk_wr) disable iff (reset)
    !$past(tx_mrk_userbit) |-> (tx_phy == '0)
  );

endmodule

`default_nettype wire

//--- lpif_pkg.sv
`default_nettype none

package lpif_pkg;

  //////////////////////////////////////////////////
  // Lane geometry
  //////////////////////////////////////////////////

  parameter int num_lanes          = 16;
  parameter int lane_width         = 40;
  parameter int lane_payload_width = 38;

  // Userbit positions above the payload
  parameter int stb_bit = lane_payload_width;
  parameter int mrk_bit = lane_payload_width + 1;

  //////////////////////////////////////////////////
  // Streaming channel fields
  //////////////////////////////////////////////////

  parameter int state_width     = 4;
  parameter int protid_width    = 2;
  parameter int user_data_width = 512;
  parameter int crc_width       = 16;
  parameter int link_word_width = 537;

  typedef logic [lane_width-1:0] lane_t;
  typedef lane_t [num_lanes-1:0] lane_bus_t;

  // Online delay counts, in clk_wr cycles
  typedef logic [15:0] delay_t;

  // One link word, top bit first
  typedef struct packed {
    logic [state_width-1:0]     state;
    logic [protid_width-1:0]    protid;
    logic [user_data_width-1:0] data;
    logic                       dvalid;
    logic [crc_width-1:0]       crc;
    logic                       crc_valid;
    logic                       valid;
  } lpif_word_t;

  // Tx online sequencer
  typedef enum logic [1:0] {
    sync_off,
    sync_count_y,
    sync_count_z,
    sync_online
  } sync_state_t;

endpackage

`default_nettype wire

//--- lpif_user_pack.sv
`timescale 1ns/1ps
`default_nettype none

module lpif_user_pack
  import lpif_pkg::*;
(
  input  wire logic                       clk_wr,
  input  wire logic                       reset,

  // Downstream user fields
  input  wire logic [state_width-1:0]     dstrm_state,
  input  wire logic [protid_width-1:0]    dstrm_protid,
  input  wire logic [user_data_width-1:0] dstrm_data,
  input  wire logic                       dstrm_dvalid,
  input  wire logic [crc_width-1:0]       dstrm_crc,
  input  wire logic                       dstrm_crc_valid,
  input  wire logic                       dstrm_valid,

  // Link side
  input  wire lpif_word_t                 rx_word,
  input  wire logic                       rx_online_delay,
  output lpif_word_t                      tx_word,

  // Upstream user fields
  output logic [state_width-1:0]          ustrm_state,
  output logic [protid_width-1:0]         ustrm_protid,
  output logic [user_data_width-1:0]      ustrm_data,
  output logic                            ustrm_dvalid,
  output logic [crc_width-1:0]            ustrm_crc,
  output logic                            ustrm_crc_valid,
  output logic                            ustrm_valid
);

  //////////////////////////////////////////////////
  // Downstream pack
  //////////////////////////////////////////////////

  // One link word per clock, no back-pressure
  always_ff @(posedge clk_wr) begin
    tx_word.state     <= dstrm_state;
    tx_word.protid    <= dstrm_protid;
    tx_word.data      <= dstrm_data;
    tx_word.dvalid    <= dstrm_dvalid;
    tx_word.crc       <= dstrm_crc;
    tx_word.crc_valid <= dstrm_crc_valid;
    tx_word.valid     <= dstrm_valid;
  end

  //////////////////////////////////////////////////
  // Upstream unpack
  //////////////////////////////////////////////////

  always_ff @(posedge clk_wr) begin
    if (reset) begin
      ustrm_state     <= '0;
      ustrm_protid    <= '0;
      ustrm_data      <= '0;
      ustrm_dvalid    <= 1'b0;
      ustrm_crc       <= '0;
      ustrm_crc_valid <= 1'b0;
      ustrm_valid     <= 1'b0;
    end else begin
      ustrm_state     <= rx_word.state;
      ustrm_protid    <= rx_word.protid;
      ustrm_data      <= rx_word.data;
      ustrm_crc       <= rx_word.crc;
      // Qualifiers only count once rx is online
      ustrm_dvalid    <= rx_word.dvalid & rx_online_delay;
      ustrm_crc_valid <= rx_word.crc_valid & rx_online_delay;
      ustrm_valid     <= rx_word.valid & rx_online_delay;
    end
  end

  // Far end keeps dvalid under valid
  a_dvalid_needs_valid: assert property (
    @(posedge clk_wr) disable iff (reset)
    ustrm_dvalid |-> ustrm_valid
  );

endmodule

`default_nettype wire

//--- lpif_x16_master_top.sv
`timescale 1ns/1ps
`default_nettype none

module lpif_x16_master_top
  import lpif_pkg::*;
#(
  parameter int STROBE_PERIOD = 16
) (
  input  wire logic                       clk_wr,
  input  wire logic                       reset,

  // Link control
  input  wire logic                       tx_online,
  input  wire logic                       rx_online,
  input  wire delay_t                     delay_x_value,
  input  wire delay_t                     delay_y_value,
  input  wire delay_t                     delay_z_value,

  // PHY lanes
  output lane_bus_t                       tx_phy,
  input  wire lane_bus_t                  rx_phy,

  // Downstream channel
  input  wire logic [state_width-1:0]     dstrm_state,
  input  wire logic [protid_width-1:0]    dstrm_protid,
  input  wire logic [user_data_width-1:0] dstrm_data,
  input  wire logic                       dstrm_dvalid,
  input  wire logic [crc_width-1:0]       dstrm_crc,
  input  wire logic                       dstrm_crc_valid,
  input  wire logic                       dstrm_valid,

  // Upstream channel
  output logic [state_width-1:0]          ustrm_state,
  output logic [protid_width-1:0]         ustrm_protid,
  output logic [user_data_width-1:0]      ustrm_data,
  output logic                            ustrm_dvalid,
  output logic [crc_width-1:0]            ustrm_crc,
  output logic                            ustrm_crc_valid,
  output logic                            ustrm_valid
);

  lpif_word_t tx_word;
  lpif_word_t rx_word;
  logic       tx_online_delay;
  logic       rx_online_delay;
  logic       tx_stb_userbit;
  logic       tx_mrk_userbit;

  //////////////////////////////////////////////////
  // Online sequencing and userbits
  //////////////////////////////////////////////////

  lpif_auto_sync #(
    .STROBE_PERIOD (STROBE_PERIOD)
  ) lpif_auto_sync_inst (
    .clk_wr          (clk_wr),
    .reset           (reset),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_y_value   (delay_y_value),
    .delay_z_value   (delay_z_value),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .tx_stb_userbit  (tx_stb_userbit),
    .tx_mrk_userbit  (tx_mrk_userbit)
  );

  //////////////////////////////////////////////////
  // User side
  //////////////////////////////////////////////////

  lpif_user_pack lpif_user_pack_inst (
    .clk_wr          (clk_wr),
    .reset           (reset),
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid     (dstrm_valid),
    .rx_word         (rx_word),
    .rx_online_delay (rx_online_delay),
    .tx_word         (tx_word),
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc       (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid),
    .ustrm_valid     (ustrm_valid)
  );

  //////////////////////////////////////////////////
  // PHY side
  //////////////////////////////////////////////////

  lpif_lane_concat lpif_lane_concat_inst (
    .clk_wr          (clk_wr),
    .reset           (reset),
    .tx_word         (tx_word),
    .tx_online_delay (tx_online_delay),
    .tx_stb_userbit  (tx_stb_userbit),
    .tx_mrk_userbit  (tx_mrk_userbit),
    .tx_phy          (tx_phy),
    .rx_phy          (rx_phy),
    .rx_word         (rx_word)
  );

endmodule

`default_nettype wire

//--- project.f
+incdir+.
lpif_pkg.sv
lpif_auto_sync.sv
lpif_user_pack.sv
lpif_lane_concat.sv
lpif_x16_master_top.sv
tb_lpif_x16_master.sv

//--- tb_lpif_tasks.svh
`ifndef TB_LPIF_TASKS_SVH
`define TB_LPIF_TASKS_SVH

//////////////////////////////////////////////////
// Helpers
//////////////////////////////////////////////////

task automatic check_value(input string name, input logic [check_width-1:0] expected,
                           input logic [check_width-1:0] actual);
  checks++;
  if (expected !== actual) begin
    errors++;
    $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
  end
endtask

// Outputs settle after the rising edge, inputs change on the falling one
task automatic next_cycle();
  @(posedge clk_wr);
  @(negedge clk_wr);
endtask

task automatic drive_word(input logic [link_word_width-1:0] w);
  {dstrm_state, dstrm_protid, dstrm_data, dstrm_dvalid,
   dstrm_crc, dstrm_crc_valid, dstrm_valid} = w;
endtask

task automatic random_word(output logic [link_word_width-1:0] w);
  logic [575:0] raw;
  for (int i = 0; i < 18; i++) begin
    raw[i*32 +: 32] = $random(seed);
  end
  w = raw[link_word_width-1:0];
  // Keep dvalid under valid
  w[valid_pos] = 1'b1;
endtask

function automatic logic [link_word_width-1:0] ustrm_word();
  return {ustrm_state, ustrm_protid, ustrm_data, ustrm_dvalid,
          ustrm_crc, ustrm_crc_valid, ustrm_valid};
endfunction

// Lane k payload bit j holds word bit k*38+j
function automatic logic [lane_payload_width-1:0] expected_payload(
    input logic [link_word_width-1:0] w, input int k);
  logic [lane_payload_width-1:0] p;
  int idx;
  p = '0;
  for (int j = 0; j < lane_payload_width; j++) begin
    idx = k * lane_payload_width + j;
    if (idx < link_word_width) begin
      p[j] = w[idx];
    end
  end
  return p;
endfunction

// One bit position taken from every lane
function automatic logic [num_lanes-1:0] lane_bits(input int b);
  logic [num_lanes-1:0] v;
  for (int k = 0; k < num_lanes; k++) begin
    v[k] = tx_phy[k][b];
  end
  return v;
endfunction

//////////////////////////////////////////////////
// Directed tests
//////////////////////////////////////////////////

task automatic test_reset();
  for (int n = 0; n < reset_cycles; n++) begin
    next_cycle();
    check_value("reset tx_phy", '0, tx_phy);
    check_value("reset ustrm valids", '0, {ustrm_valid, ustrm_dvalid, ustrm_crc_valid});
  end
  reset = 1'b0;
  next_cycle();
  check_value("after reset tx_phy", '0, tx_phy);
  check_value("after reset ustrm valids", '0, {ustrm_valid, ustrm_dvalid, ustrm_crc_valid});
endtask

// y plus z cycles in auto-sync, one more in the lane register
task automatic test_tx_online();
  logic [num_lanes-1:0] exp;
  delay_y_value = 16'd5;
  delay_z_value = 16'd3;
  tx_online     = 1'b1;
  for (int n = 1; n <= 9; n++) begin
    next_cycle();
    exp = (n == 9) ? '1 : '0;
    check_value($sformatf("tx online marker cycle %0d", n), exp, lane_bits(39));
  end
endtask

// Starts on the first online cycle
task automatic test_strobe();
  logic [num_lanes-1:0] exp;
  for (int n = 0; n < strobe_cycles; n++) begin
    exp = (n % 8 == 0) ? 16'h0001 : 16'h0000;
    check_value($sformatf("strobe cycle %0d", n), exp, lane_bits(38));
    next_cycle();
  end
endtask

task automatic test_lane_mapping();
  logic [link_word_width-1:0] w;
  for (int i = 0; i < map_words; i++) begin
    random_word(w);
    drive_word(w);
    next_cycle();
    next_cycle();
    for (int k = 0; k < num_lanes; k++) begin
      check_value($sformatf("lane map word %0d lane %0d", i, k),
                  expected_payload(w, k), tx_phy[k][lane_payload_width-1:0]);
    end
    check_value($sformatf("lane map word %0d marker", i), {num_lanes{1'b1}},
                lane_bits(39));
    check_value($sformatf("lane map word %0d strobe lanes", i), '0,
                lane_bits(38) & 16'hfffe);
  end
endtask

task automatic test_loopback();
  logic [link_word_width-1:0] words [0:stream_words-1];
  delay_x_value = 16'd3;
  rx_online     = 1'b1;
  repeat (5) next_cycle();
  for (int i = 0; i < stream_words + 4; i++) begin
    if (i >= 4) begin
      check_value($sformatf("loopback word %0d", i - 4), words[i-4], ustrm_word());
    end
    if (i < stream_words) begin
      random_word(words[i]);
      drive_word(words[i]);
    end
    next_cycle();
  end
endtask

// Qualifiers forced high so the masking shows
task automatic test_rx_gating();
  logic [link_word_width-1:0] words [0:stream_words-1];
  logic [link_word_width-1:0] exp;
  rx_online = 1'b0;
  repeat (2) next_cycle();
  for (int i = 0; i < stream_words + 4; i++) begin
    if (i >= 4) begin
      exp = words[i-4];
      exp[valid_pos]     = 1'b0;
      exp[dvalid_pos]    = 1'b0;
      exp[crc_valid_pos] = 1'b0;
      check_value($sformatf("rx gating word %0d", i - 4), exp, ustrm_word());
    end
    if (i < stream_words) begin
      random_word(words[i]);
      words[i][dvalid_pos]    = 1'b1;
      words[i][crc_valid_pos] = 1'b1;
      drive_word(words[i]);
    end
    next_cycle();
  end
endtask

task automatic test_tx_offline();
  tx_online = 1'b0;
  next_cycle();
  next_cycle();
  check_value("tx offline marker", '0, lane_bits(39));
  check_value("tx offline tx_phy", '0, tx_phy);
endtask

`endif

//--- tb_lpif_x16_master.sv
`timescale 1ns/1ps
`default_nettype none

module tb_lpif_x16_master
  import lpif_pkg::*;
();

  localparam int clk_period  = 20;
  localparam int check_width = num_lanes * lane_width;

  // Bit positions inside the link word
  localparam int valid_pos     = 0;
  localparam int crc_valid_pos = 1;
  localparam int dvalid_pos    = 18;

  // Test lengths in cycles
  localparam int reset_cycles  = 4;
  localparam int strobe_cycles = 32;
  localparam int map_words     = 4;
  localparam int stream_words  = 24;
  localparam int run_cycles    = (reset_cycles + 1) + 9 + strobe_cycles + 2 * map_words
                                 + (5 + stream_words + 4) + (2 + stream_words + 4) + 2;
  localparam int margin_cycles = 100;

  logic                       clk_wr;
  logic                       reset;
  logic                       tx_online;
  logic                       rx_online;
  delay_t                     delay_x_value;
  delay_t                     delay_y_value;
  delay_t                     delay_z_value;
  lane_bus_t                  tx_phy;
  lane_bus_t                  rx_phy;
  logic [state_width-1:0]     dstrm_state;
  logic [protid_width-1:0]    dstrm_protid;
  logic [user_data_width-1:0] dstrm_data;
  logic                       dstrm_dvalid;
  logic [crc_width-1:0]       dstrm_crc;
  logic                       dstrm_crc_valid;
  logic                       dstrm_valid;
  logic [state_width-1:0]     ustrm_state;
  logic [protid_width-1:0]    ustrm_protid;
  logic [user_data_width-1:0] ustrm_data;
  logic                       ustrm_dvalid;
  logic [crc_width-1:0]       ustrm_crc;
  logic                       ustrm_crc_valid;
  logic                       ustrm_valid;

  integer seed = 32'h2ad6;
  int     errors = 0;
  int     checks = 0;

  `include "tb_lpif_tasks.svh"

  //////////////////////////////////////////////////
  // Clock, DUT and loopback
  //////////////////////////////////////////////////

  initial clk_wr = 1'b0;
  always #(clk_period / 2) clk_wr = ~clk_wr;

  // External tx to rx wiring
  assign rx_phy = tx_phy;

  lpif_x16_master_top #(
    .STROBE_PERIOD (8)
  ) lpif_x16_master_top_inst (
    .clk_wr          (clk_wr),
    .reset           (reset),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_y_value   (delay_y_value),
    .delay_z_value   (delay_z_value),
    .tx_phy          (tx_phy),
    .rx_phy          (rx_phy),
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid     (dstrm_valid),
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc       (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid),
    .ustrm_valid     (ustrm_valid)
  );

  //////////////////////////////////////////////////
  // Watchdog
  //////////////////////////////////////////////////

  initial begin
    #((run_cycles + margin_cycles) * clk_period);
    $display("Watchdog expired before the test sequence finished");
    $display("TB FAILED");
    $finish;
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    reset         = 1'b1;
    tx_online     = 1'b0;
    rx_online     = 1'b0;
    delay_x_value = '0;
    delay_y_value = '0;
    delay_z_value = '0;
    drive_word('0);

    test_reset();
    test_tx_online();
    test_strobe();
    test_lane_mapping();
    test_loopback();
    test_rx_gating();
    test_tx_offline();

    $display("Run complete: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
